//--- hw/completion_buffer.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module completion_buffer import ooo_core_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  ooo_hazard_if.cb           hz,
  completion_buffer_if.cb    cb,
  output logic               commit_valid,
  output pc_t                commit_pc,
  output reg_idx_t           commit_rd,
  output logic               commit_wen,
  output word_t              commit_data,
  output logic               trap_valid,
  output pc_t                trap_epc
);
  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  logic [`ROB_DEPTH-1:0] done;
  logic [`ROB_DEPTH-1:0] wen_q, illegal_q;
  reg_idx_t              rd_q   [`ROB_DEPTH];
  pc_t                   pc_q   [`ROB_DEPTH];
  word_t                 data_q [`ROB_DEPTH];
  word_t                 regfile [`NUM_REGS];
  rob_tag_t              head, tail, wb_off;
  logic [CNT_W-1:0]      count;
  logic                  head_valid, trap;

  assign head_valid = (count != '0);
  assign hz.rob_full = (count == CNT_W'(`ROB_DEPTH));
  assign cb.alloc_tag = tail;

  // operand read for decode
  assign cb.rs1_data = regfile[cb.rs1_addr];
  assign cb.rs2_data = regfile[cb.rs2_addr]; 

  // illegal head traps instead of committing, it never writes back
  assign trap         = head_valid & illegal_q[head];
  assign commit_valid = head_valid & done[head] & ~illegal_q[head];
  assign commit_pc    = pc_q[head];
  assign commit_rd    = rd_q[head];
  assign commit_wen   = wen_q[head];
  assign commit_data  = data_q[head];
  assign trap_valid   = trap;
  assign trap_epc     = pc_q[head];

  assign hz.insert_priv_pc = trap;
  assign hz.priv_pc        = `TRAP_VECTOR;
  assign cb.trap           = trap;
  assign cb.busy_clear     = commit_valid & wen_q[head];
  assign cb.busy_clear_rd  = rd_q[head];

  always_ff @(posedge clk) begin
    if (!rst_n || hz.execute_commit_flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (cb.alloc) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (cb.wb_valid) begin
        done[cb.wb_tag] <= 1'b1;
      end
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      count <= count + CNT_W'(cb.alloc) - CNT_W'(commit_valid);
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (cb.alloc) begin
      rd_q[tail]      <= cb.alloc_rd;
      wen_q[tail]     <= cb.alloc_wen;
      pc_q[tail]      <= cb.alloc_pc;
      illegal_q[tail] <= cb.alloc_illegal;
    end
    if (cb.wb_valid) begin
      data_q[cb.wb_tag] <= cb.wb_data;
    end
  end

  // architectural state changes only here, in program order
  always_ff @(posedge clk) begin
    if (commit_valid && wen_q[head]) begin
      regfile[rd_q[head]] <= data_q[head];
    end
  end

  // distance from head tells whether a tag is live
  assign wb_off = cb.wb_tag - head;

  assert property (@(posedge clk) disable iff (!rst_n) cb.alloc |-> !hz.rob_full);
  assert property (@(posedge clk) disable iff (!rst_n)
    cb.wb_valid && !hz.execute_commit_flush |-> CNT_W'(wb_off) < count);

endmodule

//--- hw/completion_buffer_if.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

interface completion_buffer_if import ooo_core_pkg::*; ();
  // allocation at issue, tag comes back in the same cycle
  logic     alloc;
  reg_idx_t alloc_rd;
  logic     alloc_wen;
  pc_t      alloc_pc;
  logic     alloc_illegal;
  rob_tag_t alloc_tag;
  // register file read for the operands decode names
  reg_idx_t rs1_addr, rs2_addr;
  word_t    rs1_data, rs2_data;
  // commit frees the scoreboard bit, trap wipes it
  logic     busy_clear;
  reg_idx_t busy_clear_rd;
  logic     trap;
  // result writeback by tag
  logic     wb_valid;
  rob_tag_t wb_tag;
  word_t    wb_data;

  modport decode (
    output alloc, alloc_rd, alloc_wen, alloc_pc, alloc_illegal, rs1_addr, rs2_addr,
    input  alloc_tag, rs1_data, rs2_data, busy_clear, busy_clear_rd, trap
  );
  modport execute (
    output wb_valid, wb_tag, wb_data
  );
  modport cb (
    input  alloc, alloc_rd, alloc_wen, alloc_pc, alloc_illegal, rs1_addr, rs2_addr,
           wb_valid, wb_tag, wb_data,
    output alloc_tag, rs1_data, rs2_data, busy_clear, busy_clear_rd, trap
  );
endinterface

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module decode_stage import ooo_core_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  word_t                  fetch_word,
  input  pc_t                    fetch_pc,
  input  logic                   fetch_valid,
  ooo_hazard_if.decode           hz,
  completion_buffer_if.decode    cb,
  output logic                   issue_valid,
  output decoded_t               issue_insn,
  output rob_tag_t               issue_tag,
  output word_t                  issue_a,
  output word_t                  issue_b
);
  decoded_t dec;
  // one bit per register with an uncommitted writer
  logic [`NUM_REGS-1:0] busy;

  always_comb begin
    dec              = '0;
    dec.pc           = fetch_pc;
    dec.opcode       = opcode_t'(fetch_word[15:12]);
    dec.rd           = fetch_word[11:8];
    dec.rs1          = fetch_word[7:4];
    dec.rs2          = fetch_word[3:0];
    dec.imm          = {{(`XLEN-8){1'b0}}, fetch_word[7:0]};
    dec.source_a_sel = SRC_IMM;
    dec.source_b_sel = SRC_IMM;
    dec.fu_type      = NONE_S;
    case (dec.opcode)
      LI: begin
        dec.fu_type = ARITH_S;
        dec.wen     = 1'b1;
      end
      ADD, SUB, DIV: begin
        dec.fu_type      = (dec.opcode == DIV) ? DIV_S : ARITH_S;
        dec.source_a_sel = SRC_REG;
        dec.source_b_sel = SRC_REG;
        dec.wen          = 1'b1;
      end
      JMP: dec.fu_type = CTRL_S;
      BNZ: begin
        // tested register sits in the rd field
        dec.fu_type      = CTRL_S;
        dec.rs1          = fetch_word[11:8];
        dec.source_a_sel = SRC_REG;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

  // hazard inputs, a bubble in decode never stalls
  assign hz.rs1_busy     = fetch_valid & busy[dec.rs1];
  assign hz.rs2_busy     = fetch_valid & busy[dec.rs2];
  assign hz.rd_busy      = fetch_valid & busy[dec.rd];
  assign hz.wen          = fetch_valid & dec.wen;
  assign hz.source_a_sel = dec.source_a_sel;
  assign hz.source_b_sel = dec.source_b_sel;
  assign hz.fu_type      = fetch_valid ? dec.fu_type : NONE_S;

  // issue and allocation happen together, in program order
  assign cb.alloc         = fetch_valid & ~hz.stall_de & ~hz.decode_execute_flush;
  assign cb.alloc_rd      = dec.rd;
  assign cb.alloc_wen     = dec.wen;
  assign cb.alloc_pc      = dec.pc;
  assign cb.alloc_illegal = dec.illegal;
  assign cb.rs1_addr      = dec.rs1;
  assign cb.rs2_addr      = dec.rs2;

  always_ff @(posedge clk) begin
    if (!rst_n || cb.trap) begin
      busy <= '0;
    end else begin
      if (cb.busy_clear) begin
        busy[cb.busy_clear_rd] <= 1'b0;
      end
      if (cb.alloc && cb.alloc_wen) begin
        busy[cb.alloc_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= cb.alloc;
    end
  end

  // operands come straight from the register file, RAW already waited for commit
  always_ff @(posedge clk) begin
    if (cb.alloc) begin
      issue_insn <= dec;
      issue_tag  <= cb.alloc_tag;
      issue_a    <= cb.rs1_data;
      issue_b    <= cb.rs2_data;
    end
  end

  // a stall leaves a bubble in the execute register
  assert property (@(posedge clk) disable iff (!rst_n) hz.stall_de |=> !issue_valid);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module execute_stage import ooo_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid,
  input  decoded_t              issue_insn,
  input  rob_tag_t              issue_tag,
  input  word_t                 issue_a,
  input  word_t                 issue_b,
  ooo_hazard_if.execute         hz,
  completion_buffer_if.execute  cb
);
  localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

  logic             fast_valid;
  word_t            fast_data;
  logic             div_start, div_busy, div_done;
  logic [CNT_W-1:0] div_cnt;
  rob_tag_t         div_tag;
  word_t            div_rem, div_quo, div_dvs;
  logic [`XLEN:0]   trial;

  // single-cycle path, control ops write back too so they can commit
  assign fast_valid = issue_valid &
                      ((issue_insn.fu_type == ARITH_S) | (issue_insn.fu_type == CTRL_S));

  always_comb begin
    case (issue_insn.opcode)
      LI:      fast_data = issue_insn.imm;
      ADD:     fast_data = issue_a + issue_b;
      SUB:     fast_data = issue_a - issue_b;
      default: fast_data = '0;
    endcase
  end

  // branch resolution, taken BNZ means the not-taken guess was wrong
  assign hz.jump       = issue_valid & (issue_insn.opcode == JMP);
  assign hz.branch     = issue_valid & (issue_insn.opcode == BNZ);
  assign hz.mispredict = (issue_a != '0);
  assign hz.br_target  = issue_insn.imm[`PC_W-1:0];

  assign div_start  = issue_valid & (issue_insn.fu_type == DIV_S);
  assign div_done   = div_busy & (div_cnt == '0);
  // busy already while the DIV sits in the execute register
  assign hz.busy_du = div_busy | div_start;

  // trial subtract of the shifted partial remainder
  assign trial = {div_rem, div_quo[`XLEN-1]} - {1'b0, div_dvs};

  always_ff @(posedge clk) begin
    if (!rst_n || hz.execute_commit_flush) begin
      div_busy <= 1'b0;
      div_cnt  <= '0;
    end else if (div_start) begin
      div_busy <= 1'b1;
      div_cnt  <= CNT_W'(`DIV_CYCLES);
    end else if (div_done && !fast_valid) begin
      // quotient leaves on a free writeback slot
      div_busy <= 1'b0;
    end else if (div_busy && div_cnt != '0) begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // restoring division, divide by zero ends up with all ones
  always_ff @(posedge clk) begin
    if (div_start) begin
      div_rem <= '0;
      div_quo <= issue_a;
      div_dvs <= issue_b;
      div_tag <= issue_tag;
    end else if (div_busy && div_cnt != '0) begin
      if (!trial[`XLEN]) begin
        div_rem <= trial[`XLEN-1:0];
        div_quo <= {div_quo[`XLEN-2:0], 1'b1};
      end else begin
        div_rem <= {div_rem[`XLEN-2:0], div_quo[`XLEN-1]};
        div_quo <= {div_quo[`XLEN-2:0], 1'b0};
      end
    end
  end

  // one writeback port, the fast path has it first
  assign cb.wb_valid = fast_valid | div_done;
  assign cb.wb_tag   = fast_valid ? issue_tag : div_tag;
  assign cb.wb_data  = fast_valid ? fast_data : div_quo;

  assert property (@(posedge clk) disable iff (!rst_n) div_start |-> !div_busy);

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module fetch_stage import ooo_core_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  ooo_hazard_if.fetch      hz,
  input  word_t            imem_rdata,
  output pc_t              imem_addr,
  output word_t            fetch_word,
  output pc_t              fetch_pc,
  output logic             fetch_valid
);
  pc_t pc;
  pc_t pc_next;

  assign imem_addr = pc;

  // trap vector first, then the resolved branch target, then sequential
  always_comb begin
    if (hz.insert_priv_pc) begin
      pc_next = hz.priv_pc;
    end else if (hz.npc_sel) begin
      pc_next = hz.br_target;
    end else if (hz.pc_en) begin
      pc_next = pc + 1'b1;
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc          <= `RESET_PC;
      fetch_valid <= 1'b0;
    end else begin
      pc <= pc_next;
      if (hz.fetch_decode_flush) begin
        fetch_valid <= 1'b0;
      end else if (!hz.stall_de) begin
        // decode drains this cycle, a busy memory leaves a bubble behind
        fetch_valid <= ~hz.i_mem_busy;
      end
    end
  end

  // held as long as decode is stalled
  always_ff @(posedge clk) begin
    if (!hz.stall_de) begin
      fetch_word <= imem_rdata;
      fetch_pc   <= pc;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    hz.i_mem_busy && !hz.npc_sel && !hz.insert_priv_pc |=> $stable(pc));

endmodule

//--- hw/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module ooo_core import ooo_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output pc_t      imem_addr,
  input  word_t    imem_rdata,
  input  logic     imem_busy,
  output logic     commit_valid,
  output pc_t      commit_pc,
  output reg_idx_t commit_rd,
  output logic     commit_wen,
  output word_t    commit_data,
  output logic     trap_valid,
  output pc_t      trap_epc
);
  word_t    fetch_word;
  pc_t      fetch_pc;
  logic     fetch_valid;
  logic     issue_valid;
  decoded_t issue_insn;
  rob_tag_t issue_tag;
  word_t    issue_a, issue_b;

  ooo_hazard_if hz_if (
    .clk   (clk),
    .rst_n (rst_n)
  );
  completion_buffer_if cb_if ();

  // memory busy enters the hazard merge next to the fetch signals
  assign hz_if.i_mem_busy = imem_busy;

  ooo_hazard_unit u_hazard (
    .hazard_if (hz_if.hazard_unit)
  );

  fetch_stage u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .hz          (hz_if.fetch),
    .imem_rdata  (imem_rdata),
    .imem_addr   (imem_addr),
    .fetch_word  (fetch_word),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_word  (fetch_word),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .hz          (hz_if.decode),
    .cb          (cb_if.decode),
    .issue_valid (issue_valid),
    .issue_insn  (issue_insn),
    .issue_tag   (issue_tag),
    .issue_a     (issue_a),
    .issue_b     (issue_b)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_insn  (issue_insn),
    .issue_tag   (issue_tag),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .hz          (hz_if.execute),
    .cb          (cb_if.execute)
  );

  completion_buffer u_cb (
    .clk          (clk),
    .rst_n        (rst_n),
    .hz           (hz_if.cb),
    .cb           (cb_if.cb),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data),
    .trap_valid   (trap_valid),
    .trap_epc     (trap_epc)
  );

endmodule

//--- hw/ooo_core_pkg.sv
`include "ooo_core_settings.svh"

package ooo_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`PC_W-1:0] pc_t;
  typedef logic [`REG_AW-1:0] reg_idx_t;

  // opcode lives in insn[15:12], anything not listed here traps
  typedef enum logic [3:0] {
    LI  = 4'd1,
    ADD = 4'd2,
    SUB = 4'd3,
    DIV = 4'd4,
    JMP = 4'd5,
    BNZ = 4'd6
  } opcode_t;

  // unit that produces the writeback
  typedef enum logic [1:0] {
    ARITH_S,
    DIV_S,
    CTRL_S,
    NONE_S
  } fu_type_t;

  // an operand taken from the immediate is never hazard-checked
  typedef enum logic {
    SRC_REG,
    SRC_IMM
  } src_sel_t;

  typedef struct packed {
    pc_t      pc;
    opcode_t  opcode;
    fu_type_t fu_type;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    src_sel_t source_a_sel;
    src_sel_t source_b_sel;
    logic     wen;
    word_t    imm;
    logic     illegal;
  } decoded_t;

  // completion buffer entry index
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage

//--- hw/ooo_core_settings.svh
`ifndef OOO_CORE_SETTINGS_SVH
`define OOO_CORE_SETTINGS_SVH

// data path and register width
`define XLEN 16
// word-addressed instruction memory, one instruction per address
`define PC_W 8
// architectural register file
`define NUM_REGS 16
`define REG_AW 4

// fetch addresses after reset and after an illegal-instruction trap
`define RESET_PC 8'h00
`define TRAP_VECTOR 8'hF0

// restoring divider runs one iteration per quotient bit
`define DIV_CYCLES 16

// completion buffer size, tag width follows from it
`define ROB_DEPTH 4
`define ROB_TAG_W $clog2(`ROB_DEPTH)

`endif

//--- hw/ooo_hazard_if.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

interface ooo_hazard_if import ooo_core_pkg::*; (
  input logic clk,
  input logic rst_n
);
  // conditions reported by the stages
  logic     i_mem_busy;
  logic     rs1_busy, rs2_busy, rd_busy;
  src_sel_t source_a_sel, source_b_sel;
  logic     wen;
  fu_type_t fu_type;
  logic     busy_du;
  logic     rob_full;
  logic     jump, branch, mispredict;
  pc_t      br_target;
  logic     insert_priv_pc;
  pc_t      priv_pc;

  // merged control back to the stages
  logic pc_en, npc_sel, stall_de;
  logic fetch_decode_flush, decode_execute_flush, execute_commit_flush;

  modport hazard_unit (
    input  clk, rst_n, i_mem_busy, rs1_busy, rs2_busy, rd_busy, source_a_sel,
           source_b_sel, wen, fu_type, busy_du, rob_full, jump, branch,
           mispredict, insert_priv_pc,
    output pc_en, npc_sel, stall_de, fetch_decode_flush, decode_execute_flush,
           execute_commit_flush
  );
  modport fetch (
    input i_mem_busy, pc_en, npc_sel, stall_de, fetch_decode_flush, br_target,
          insert_priv_pc, priv_pc
  );
  modport decode (
    output rs1_busy, rs2_busy, rd_busy, source_a_sel, source_b_sel, wen, fu_type,
    input  stall_de, decode_execute_flush
  );
  modport execute (
    output busy_du, jump, branch, mispredict, br_target,
    input  execute_commit_flush
  );
  modport cb (
    output rob_full, insert_priv_pc, priv_pc,
    input  execute_commit_flush
  );
endinterface

//--- hw/ooo_hazard_unit.sv
`timescale 1ns/1ps

module ooo_hazard_unit import ooo_core_pkg::*; (
  ooo_hazard_if.hazard_unit hazard_if
);
  logic rs1_hazard, rs2_hazard, rd_hazard;
  logic data_hazard;
  logic div_hazard;
  logic branch_jump;

  // only register operands can be waiting on an older writer
  always_comb begin
    case (hazard_if.source_a_sel)
      SRC_REG: rs1_hazard = hazard_if.rs1_busy;
      default: rs1_hazard = 1'b0;
    endcase
  end

  always_comb begin
    case (hazard_if.source_b_sel)
      SRC_REG: rs2_hazard = hazard_if.rs2_busy;
      default: rs2_hazard = 1'b0;
    endcase
  end

  // WAW, rd still owned by an uncommitted entry
  assign rd_hazard   = hazard_if.rd_busy & hazard_if.wen;
  assign data_hazard = rs1_hazard | rs2_hazard | rd_hazard;

  // single divider, a second DIV waits in decode
  assign div_hazard = hazard_if.busy_du & (hazard_if.fu_type == DIV_S);

  assign hazard_if.stall_de = data_hazard | div_hazard | hazard_if.rob_full;

  // pc moves only when the word is there and decode can take the next one
  assign hazard_if.pc_en = ~(hazard_if.i_mem_busy | hazard_if.stall_de | data_hazard);

  // not-taken prediction, so a taken BNZ is a mispredict
  assign branch_jump       = hazard_if.jump | (hazard_if.branch & hazard_if.mispredict);
  // trap redirect wins over a branch redirect
  assign hazard_if.npc_sel = branch_jump & ~hazard_if.insert_priv_pc;

  // a redirect kills whatever is younger in fetch and decode
  assign hazard_if.fetch_decode_flush   = hazard_if.npc_sel | hazard_if.insert_priv_pc;
  assign hazard_if.decode_execute_flush = hazard_if.npc_sel | hazard_if.insert_priv_pc;

  // only a trap reaches into execute and the completion buffer
  assign hazard_if.execute_commit_flush = hazard_if.insert_priv_pc;

  // a trap empties the buffer and the execute register on its edge,
  // so the following cycle can neither trap nor branch
  assert property (@(posedge hazard_if.clk) disable iff (!hazard_if.rst_n)
    hazard_if.insert_priv_pc |=> !hazard_if.insert_priv_pc && !hazard_if.npc_sel);

endmodule

//--- ooo_core.f
+incdir+hw
hw/ooo_core_pkg.sv
hw/ooo_hazard_if.sv
hw/completion_buffer_if.sv
hw/ooo_hazard_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/completion_buffer.sv
hw/ooo_core.sv
tb/ooo_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the run printed the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module ooo_core_tb -f ooo_core.f &&
sim_out=$(./obj_dir/Vooo_core_tb 2>&1; true) &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "Testbench passed" &&
echo "run_sim: OK" ||
{ echo "run_sim: FAILED"; exit 1; }

//--- tb/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_core_settings.svh"

module ooo_core_tb;

  // instruction set encodings, bits 15:12
  localparam logic [3:0] OP_LI  = 4'h1;
  localparam logic [3:0] OP_ADD = 4'h2;
  localparam logic [3:0] OP_SUB = 4'h3;
  localparam logic [3:0] OP_DIV = 4'h4;
  localparam logic [3:0] OP_JMP = 4'h5;
  localparam logic [3:0] OP_BNZ = 4'h6;

  localparam int   MAX_RECORDS = 64;
  localparam int   MEM_WORDS   = 1 << `PC_W;
  localparam logic KIND_COMMIT = 1'b0;
  localparam logic KIND_TRAP   = 1'b1;

  logic                clk;
  logic                rst_n;
  logic [`PC_W-1:0]    imem_addr;
  logic [`XLEN-1:0]    imem_rdata;
  logic                imem_busy;
  logic                commit_valid;
  logic [`PC_W-1:0]    commit_pc;
  logic [`REG_AW-1:0]  commit_rd;
  logic                commit_wen;
  logic [`XLEN-1:0]    commit_data;
  logic                trap_valid;
  logic [`PC_W-1:0]    trap_epc;

  logic [`XLEN-1:0] imem [0:MEM_WORDS-1];

  // expected retirement stream, commits and traps in program order
  logic               exp_kind [MAX_RECORDS];
  logic [`PC_W-1:0]   exp_pc   [MAX_RECORDS];
  logic [`REG_AW-1:0] exp_rd   [MAX_RECORDS];
  logic               exp_wen  [MAX_RECORDS];
  logic [`XLEN-1:0]   exp_data [MAX_RECORDS];
  int                 exp_count;
  int                 rec_idx;
  int                 error_count;
  int                 cycle_count;
  int                 timeout_cycles;
  // seeded before any process runs, the memory model steps it from the first edge
  logic [31:0]        rng_state = 32'd54;

  ooo_core dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .imem_busy    (imem_busy),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data),
    .trap_valid   (trap_valid),
    .trap_epc     (trap_epc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string line);
    error_count++;
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  // xorshift32, one step per cycle
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [15:0] enc_reg(input logic [3:0] op, rd, rs1, rs2);
    return {op, rd, rs1, rs2};
  endfunction

  function automatic logic [15:0] enc_imm(input logic [3:0] op, rd, input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic load_program();
    logic [`PC_W-1:0] tv;
    tv = `TRAP_VECTOR;
    // every unused word jumps onto itself, a stray fetch stays put
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = enc_imm(OP_JMP, 4'h0, a[7:0]);
    end
    // back-to-back RAW chain
    imem[0]  = enc_imm(OP_LI, 4'd1, 8'd20);
    imem[1]  = enc_imm(OP_LI, 4'd2, 8'd7);
    imem[2]  = enc_reg(OP_ADD, 4'd3, 4'd1, 4'd2);
    imem[3]  = enc_reg(OP_SUB, 4'd4, 4'd3, 4'd2);
    imem[4]  = enc_reg(OP_ADD, 4'd5, 4'd4, 4'd3);
    imem[5]  = enc_reg(OP_SUB, 4'd6, 4'd5, 4'd1);
    // long divide overtaken by independent adds, then a divide by zero
    imem[6]  = enc_imm(OP_LI, 4'd7, 8'd200);
    imem[7]  = enc_imm(OP_LI, 4'd8, 8'd9);
    imem[8]  = enc_reg(OP_DIV, 4'd9, 4'd7, 4'd8);
    imem[9]  = enc_reg(OP_ADD, 4'd10, 4'd1, 4'd2);
    imem[10] = enc_reg(OP_ADD, 4'd11, 4'd1, 4'd1);
    imem[11] = enc_reg(OP_SUB, 4'd12, 4'd2, 4'd1);
    imem[12] = enc_imm(OP_LI, 4'd13, 8'd0);
    imem[13] = enc_reg(OP_DIV, 4'd14, 4'd7, 4'd13);
    // WAW on r3, divide first, then the add that must win
    imem[14] = enc_reg(OP_DIV, 4'd3, 4'd7, 4'd2);
    imem[15] = enc_reg(OP_ADD, 4'd3, 4'd1, 4'd8);
    imem[16] = enc_reg(OP_ADD, 4'd15, 4'd3, 4'd3);
    // taken jump, not-taken branch, taken branch
    imem[17] = enc_imm(OP_JMP, 4'd0, 8'd20);
    imem[18] = enc_imm(OP_LI, 4'd1, 8'd99);
    imem[19] = enc_imm(OP_LI, 4'd2, 8'd99);
    imem[20] = enc_imm(OP_BNZ, 4'd13, 8'd30);
    imem[21] = enc_imm(OP_BNZ, 4'd1, 8'd24);
    imem[22] = enc_imm(OP_LI, 4'd1, 8'd77);
    imem[23] = enc_imm(OP_LI, 4'd2, 8'd77);
    // illegal word behind a pending divide
    imem[24] = enc_reg(OP_DIV, 4'd4, 4'd15, 4'd2);
    imem[25] = 16'hF123;
    imem[26] = enc_imm(OP_LI, 4'd5, 8'd55);
    imem[27] = enc_reg(OP_ADD, 4'd6, 4'd1, 4'd1);
    imem[28] = enc_imm(OP_LI, 4'd7, 8'd1);
    // trap handler code
    imem[tv]         = enc_imm(OP_LI, 4'd1, 8'd5);
    imem[tv + 8'd1]  = enc_reg(OP_ADD, 4'd2, 4'd1, 4'd15);
    imem[tv + 8'd2]  = enc_imm(OP_BNZ, 4'd2, tv + 8'd4);
    imem[tv + 8'd3]  = enc_imm(OP_LI, 4'd2, 8'd1);
    imem[tv + 8'd4]  = enc_reg(OP_SUB, 4'd3, 4'd2, 4'd1);
    imem[tv + 8'd5]  = enc_imm(OP_JMP, 4'd0, tv + 8'd5);
  endtask

  function automatic void add_record(input logic kind, input logic [`PC_W-1:0] pc,
                                     input logic [3:0] rd, input logic wen,
                                     input logic [`XLEN-1:0] data);
    if (exp_count < MAX_RECORDS) begin
      exp_kind[exp_count] = kind;
      exp_pc[exp_count]   = pc;
      exp_rd[exp_count]   = rd;
      exp_wen[exp_count]  = wen;
      exp_data[exp_count] = data;
      exp_count++;
    end
  endfunction

  // architectural model, one instruction per step, no timing at all
  function automatic void run_reference_model();
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [`PC_W-1:0] pc;
    logic [`PC_W-1:0] target;
    logic [`XLEN-1:0] insn;
    logic [`XLEN-1:0] a_val;
    logic [`XLEN-1:0] b_val;
    logic [`XLEN-1:0] result;
    logic [3:0]       rd;
    logic             halted;
    int               steps;
    for (int r = 0; r < `NUM_REGS; r++) begin
      regs[r] = '0;
    end
    exp_count = 0;
    pc        = `RESET_PC;
    halted    = 1'b0;
    steps     = 0;
    while (!halted && steps < 200) begin
      insn   = imem[pc];
      rd     = insn[11:8];
      a_val  = regs[insn[7:4]];
      b_val  = regs[insn[3:0]];
      target = insn[7:0];
      steps++;
      case (insn[15:12])
        OP_LI, OP_ADD, OP_SUB, OP_DIV: begin
          case (insn[15:12])
            OP_LI:   result = {{(`XLEN-8){1'b0}}, insn[7:0]};
            OP_ADD:  result = a_val + b_val;
            OP_SUB:  result = a_val - b_val;
            // unsigned quotient, zero divisor gives all ones
            default: result = (b_val == '0) ? {`XLEN{1'b1}} : a_val / b_val;
          endcase
          regs[rd] = result;
          add_record(KIND_COMMIT, pc, rd, 1'b1, result);
          pc = pc + 1'b1;
        end
        OP_JMP: begin
          add_record(KIND_COMMIT, pc, rd, 1'b0, '0);
          // a jump onto itself ends the program
          halted = (target == pc);
          pc = target;
        end
        OP_BNZ: begin
          add_record(KIND_COMMIT, pc, rd, 1'b0, '0);
          pc = (regs[rd] != '0) ? target : pc + 1'b1;
        end
        default: begin
          add_record(KIND_TRAP, pc, rd, 1'b0, '0);
          pc = `TRAP_VECTOR;
        end
      endcase
    end
  endfunction

  // memory answers for the address held since the last rising edge
  always @(negedge clk) begin
    rng_state = next_random(rng_state);
    imem_busy  <= (rng_state[9:8] == 2'b00);
    imem_rdata <= imem[imem_addr];
  end

  // commit outputs come from registers only, mid-cycle is a safe sample point
  always @(negedge clk) begin
    if (rst_n && (commit_valid || trap_valid) && rec_idx < exp_count) begin
      assert (!(commit_valid && trap_valid))
        else stop_with_failure($sformatf("[ERROR] %0t: commit and trap in one cycle", $time));
      if (commit_valid) begin
        assert (exp_kind[rec_idx] == KIND_COMMIT)
          else stop_with_failure($sformatf("[ERROR] %0t: commit of pc %h, expected trap at %h",
                                           $time, commit_pc, exp_pc[rec_idx]));
        assert (commit_pc == exp_pc[rec_idx])
          else stop_with_failure($sformatf("[ERROR] %0t: commit pc %h, expected %h",
                                           $time, commit_pc, exp_pc[rec_idx]));
        assert (commit_wen == exp_wen[rec_idx])
          else stop_with_failure($sformatf("[ERROR] %0t: pc %h commit wen %b, expected %b",
                                           $time, commit_pc, commit_wen, exp_wen[rec_idx]));
        // rd and data only matter for a register write
        if (exp_wen[rec_idx]) begin
          assert (commit_rd == exp_rd[rec_idx])
            else stop_with_failure($sformatf("[ERROR] %0t: pc %h commit rd %0d, expected %0d",
                                             $time, commit_pc, commit_rd, exp_rd[rec_idx]));
          assert (commit_data == exp_data[rec_idx])
            else stop_with_failure($sformatf("[ERROR] %0t: pc %h commit data %h, expected %h",
                                             $time, commit_pc, commit_data, exp_data[rec_idx]));
        end
      end else begin
        assert (exp_kind[rec_idx] == KIND_TRAP)
          else stop_with_failure($sformatf("[ERROR] %0t: trap at pc %h, expected commit of %h",
                                           $time, trap_epc, exp_pc[rec_idx]));
        assert (trap_epc == exp_pc[rec_idx])
          else stop_with_failure($sformatf("[ERROR] %0t: trap epc %h, expected %h",
                                           $time, trap_epc, exp_pc[rec_idx]));
      end
      rec_idx <= rec_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
      stop_with_failure($sformatf("Timeout: %0d of %0d expected commits seen after %0d cycles",
                                  rec_idx, exp_count, cycle_count));
    end
  end

  initial begin
    rst_n       = 1'b0;
    imem_busy   = 1'b0;
    imem_rdata  = '0;
    rec_idx     = 0;
    error_count = 0;
    cycle_count = 0;
    load_program();
    run_reference_model();
    // worst record is a divide plus pipeline refill, doubled for memory stalls
    timeout_cycles = exp_count * (`DIV_CYCLES + 4) * 2;
    repeat (5) @(negedge clk);
    rst_n <= 1'b1;
    wait (rec_idx == exp_count);
    @(negedge clk);
    if (error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure("run ended with failed checks");
    end
  end

endmodule
